// File: am_lock_pkg.sv
`default_nettype none

package am_lock_pkg;

	localparam int N_ALIGNERS_MAX     = 20;	// lanes in the marker table
	localparam int NB_AM_CODE         = 24;	// M0..M2
	localparam int NB_VALID_CNT_MAX   = 5;	// lock threshold field
	localparam int NB_INVALID_CNT_MAX = 3;	// unlock threshold field
	localparam int NB_CSR_ADDR        = 5;	// byte address, regs up to 0x14
	localparam int NB_CSR_DATA        = 32;

	localparam logic [1:0] SYNC_CTRL = 2'b10;	// control block header

	// per-lane {M0, M1, M2}, 100GBASE-R lane order
	localparam logic [NB_AM_CODE-1:0] am_code_table [N_ALIGNERS_MAX] = '{
		24'hC16821, 24'h9D718E, 24'h594BE8, 24'h4D957B, 24'hF50709,
		24'hDD14C2, 24'h9A4A26, 24'h7B4566, 24'hA02476, 24'h68C9FB,
		24'hFD6C99, 24'hB99155, 24'h5CB9B2, 24'h1AF8BD, 24'h83C7CA,
		24'h3536CD, 24'hC4314C, 24'hADD6B7, 24'h5F662A, 24'hC0F0E5
	};

	// 64b block payload, big endian like fig 82-5 (M0 in the top byte)
	typedef union packed {
		logic [63:0] data;	// plain data word
		struct packed {
			logic [7:0] m0;
			logic [7:0] m1;
			logic [7:0] m2;
			logic [7:0] bip3;
			logic [7:0] m4;	// ~m0
			logic [7:0] m5;	// ~m1
			logic [7:0] m6;	// ~m2
			logic [7:0] bip7;	// ~bip3
		} am;
	} block66_payload_u;

endpackage

`default_nettype wire

// File: am_matcher.sv
`timescale 1ns/100ps
`default_nettype none

module am_matcher
	import am_lock_pkg::*;
#(
	parameter N_ALIGNERS = N_ALIGNERS_MAX
)
(
	input  wire                     i_clock,
	input  wire                     i_rst_n,
	input  wire                     i_valid,
	input  wire                     i_block_lock,
	input  wire [1:0]               i_sync_header,
	input  wire block66_payload_u   i_payload,
	input  wire [N_ALIGNERS-1:0]    i_match_mask,	// search mask from the FSM
	output logic                    o_valid,
	output logic                    o_block_lock,
	output logic [N_ALIGNERS-1:0]   o_match_vector,
	output logic                    o_am_valid
);

	logic [NB_AM_CODE-1:0] am_code;
	logic                  is_ctrl;
	logic                  is_compl;
	logic                  is_marker;
	logic [N_ALIGNERS-1:0] hit;

	assign am_code   = {i_payload.am.m0, i_payload.am.m1, i_payload.am.m2};
	assign is_ctrl   = (i_sync_header == SYNC_CTRL);
	// M4..M6 must be the inverse of M0..M2
	assign is_compl  = ({i_payload.am.m4, i_payload.am.m5, i_payload.am.m6} == ~am_code);
	assign is_marker = is_ctrl & is_compl;

	// one comparator per lane code
	always_comb
	begin
		for (int i = 0; i < N_ALIGNERS; i++)
			hit[i] = is_marker && (am_code == am_code_table[i]);
	end

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_valid      <= 1'b0;
			o_block_lock <= 1'b0;
			o_am_valid   <= 1'b0;
		end
		else
		begin
			o_valid      <= i_valid;
			o_block_lock <= i_block_lock;
			o_am_valid   <= |(hit & i_match_mask);	// any hit left unmasked
		end
	end

	// raw hits, FSM narrows the mask from these
	always_ff @(posedge i_clock)
		o_match_vector <= hit;

endmodule

`default_nettype wire

// File: am_lock_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module am_lock_fsm
#(
	parameter N_ALIGNERS     = 20,
	parameter NB_AM_PERIOD   = 14,
	parameter NB_VALID_CNT   = 5,
	parameter NB_INVALID_CNT = 3
)
(
	input  wire                      i_clock,
	input  wire                      i_rst_n,
	input  wire                      i_enable,
	input  wire                      i_valid,
	input  wire                      i_block_lock,
	input  wire                      i_am_valid,
	input  wire [N_ALIGNERS-1:0]     i_match_vector,
	input  wire [NB_VALID_CNT-1:0]   i_lock_thr,	// good markers needed to lock
	input  wire [NB_INVALID_CNT-1:0] i_unlock_thr,	// missing markers tolerated
	input  wire [NB_AM_PERIOD-1:0]   i_am_period,	// blocks between markers
	output logic [N_ALIGNERS-1:0]    o_match_mask,
	output logic                     o_am_lock,
	output logic                     o_start_of_lane,
	output logic                     o_resync_by_am_start
);

	// one-hot states
	localparam logic [3:0] INIT     = 4'b1000;
	localparam logic [3:0] WAIT_1ST = 4'b0100;
	localparam logic [3:0] WAIT_2ND = 4'b0010;
	localparam logic [3:0] LOCKED   = 4'b0001;

	logic [3:0]                state, next_state;
	logic                      am_lock_next;
	logic [N_ALIGNERS-1:0]     match_mask_next;
	logic [NB_AM_PERIOD-1:0]   timer_search;	// marker search position
	logic [NB_AM_PERIOD-1:0]   timer_lane;	// start-of-lane position
	logic [NB_VALID_CNT-1:0]   valid_cnt;
	logic [NB_INVALID_CNT-1:0] invalid_cnt;
	logic                      first_lock;	// set after first lock since INIT
	logic                      adv, search_done, lane_done;
	logic                      valid_full, invalid_full;
	logic                      lock_event, rst_search, rst_valid_cnt, clr_invalid_cnt;

	assign adv          = i_enable & i_valid;
	assign search_done  = (timer_search == i_am_period);
	assign lane_done    = (timer_lane == i_am_period);
	assign valid_full   = (valid_cnt == i_lock_thr);
	assign invalid_full = (invalid_cnt == i_unlock_thr);

	always_comb
	begin
		next_state      = state;
		am_lock_next    = o_am_lock;
		match_mask_next = o_match_mask;
		lock_event      = 1'b0;
		rst_search      = 1'b0;
		rst_valid_cnt   = 1'b0;
		clr_invalid_cnt = 1'b0;
		case (state)
			INIT:
			begin
				am_lock_next    = 1'b0;
				match_mask_next = '1;
				rst_valid_cnt   = 1'b1;
				next_state      = WAIT_1ST;
			end
			WAIT_1ST:
			if (i_am_valid)
			begin
				rst_search      = 1'b1;	// align search timer to this marker
				rst_valid_cnt   = 1'b1;
				match_mask_next = i_match_vector;	// narrow to the lane seen
				next_state      = WAIT_2ND;
			end
			WAIT_2ND:
			if (search_done && i_am_valid && valid_full)
			begin
				am_lock_next    = 1'b1;
				lock_event      = 1'b1;
				clr_invalid_cnt = 1'b1;
				next_state      = LOCKED;
			end
			else if (search_done && !i_am_valid)
			begin
				match_mask_next = '1;	// marker missing, search again
				next_state      = WAIT_1ST;
			end
			LOCKED:
			if (search_done && i_am_valid)
				clr_invalid_cnt = 1'b1;
			else if (search_done && !i_am_valid && invalid_full)
			begin
				am_lock_next    = 1'b0;
				match_mask_next = '1;
				rst_valid_cnt   = 1'b1;
				clr_invalid_cnt = 1'b1;
				next_state      = WAIT_1ST;
			end
			default:
				next_state = INIT;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state        <= INIT;
			o_am_lock    <= 1'b0;
			o_match_mask <= '1;
		end
		else if (!i_block_lock)	// block lock lost, restart at once
		begin
			state        <= INIT;
			o_am_lock    <= 1'b0;
			o_match_mask <= '1;
		end
		else if (adv)
		begin
			state        <= next_state;
			o_am_lock    <= am_lock_next;
			o_match_mask <= match_mask_next;
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			timer_search <= NB_AM_PERIOD'(1);
			timer_lane   <= NB_AM_PERIOD'(1);
		end
		else
		begin
			if (adv && rst_search)
				timer_search <= NB_AM_PERIOD'(1);
			else if (i_valid)
				timer_search <= search_done ? NB_AM_PERIOD'(1) : timer_search + 1'b1;
			if (adv && lock_event)	// lane timer follows the new lock position
				timer_lane <= NB_AM_PERIOD'(1);
			else if (i_valid)
				timer_lane <= lane_done ? NB_AM_PERIOD'(1) : timer_lane + 1'b1;
		end
	end

	// good marker run and missing marker run, both sampled at search expiry
	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			valid_cnt   <= '0;
			invalid_cnt <= '0;
		end
		else if (adv)
		begin
			if (rst_valid_cnt)
				valid_cnt <= '0;
			else if (search_done)
				valid_cnt <= i_am_valid ? valid_cnt + 1'b1 : '0;
			if (clr_invalid_cnt)
				invalid_cnt <= '0;
			else if (search_done && !i_am_valid)
				invalid_cnt <= invalid_cnt + 1'b1;
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			first_lock <= 1'b0;
		else if (state == INIT)
			first_lock <= 1'b0;
		else if (adv && lock_event)
			first_lock <= 1'b1;
	end

	assign o_start_of_lane = i_valid & lane_done;
	// first lock, or relock at a different position, needs a new deskew
	assign o_resync_by_am_start = adv & lock_event & (!first_lock || (timer_lane != timer_search));

endmodule

`default_nettype wire

// File: am_lane_status.sv
`timescale 1ns/100ps
`default_nettype none

module am_lane_status
#(
	parameter N_ALIGNERS = 20
)
(
	input  wire                  i_clock,
	input  wire                  i_rst_n,
	input  wire                  i_am_lock,
	input  wire [N_ALIGNERS-1:0] i_match_mask,	// one-hot once locked
	input  wire                  i_resync,
	output logic [4:0]           o_lane_id,
	output logic [15:0]          o_resync_count
);

	logic [4:0] lane_enc;

	// index of lowest set bit, all ones if empty
	always_comb
	begin
		lane_enc = '1;
		for (int i = N_ALIGNERS - 1; i >= 0; i--)
			if (i_match_mask[i])
				lane_enc = 5'(i);
	end

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_lane_id      <= '1;	// no lane yet
			o_resync_count <= '0;
		end
		else
		begin
			o_lane_id <= i_am_lock ? lane_enc : 5'h1F;
			if (i_resync && (o_resync_count != 16'hFFFF))	// saturate
				o_resync_count <= o_resync_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: am_csr_axil.sv
`timescale 1ns/100ps
`default_nettype none

module am_csr_axil
	import am_lock_pkg::*;
#(
	parameter NB_AM_PERIOD   = 14,
	parameter NB_VALID_CNT   = NB_VALID_CNT_MAX,
	parameter NB_INVALID_CNT = NB_INVALID_CNT_MAX
)
(
	input  wire                       i_clock,
	input  wire                       i_rst_n,
	input  wire [NB_CSR_ADDR-1:0]     i_awaddr,
	input  wire                       i_awvalid,
	output logic                      o_awready,
	input  wire [NB_CSR_DATA-1:0]     i_wdata,
	input  wire                       i_wvalid,
	output logic                      o_wready,
	output logic                      o_bvalid,
	input  wire                       i_bready,
	input  wire [NB_CSR_ADDR-1:0]     i_araddr,
	input  wire                       i_arvalid,
	output logic                      o_arready,
	output logic [NB_CSR_DATA-1:0]    o_rdata,
	output logic                      o_rvalid,
	input  wire                       i_rready,
	input  wire                       i_am_lock,
	input  wire [4:0]                 i_lane_id,
	input  wire [15:0]                i_resync_count,
	output logic                      o_enable,
	output logic [NB_VALID_CNT-1:0]   o_lock_thr,
	output logic [NB_INVALID_CNT-1:0] o_unlock_thr,
	output logic [NB_AM_PERIOD-1:0]   o_am_period
);

	localparam logic [NB_CSR_ADDR-1:0] ADDR_ENABLE = 5'h00;
	localparam logic [NB_CSR_ADDR-1:0] ADDR_LOCK   = 5'h04;
	localparam logic [NB_CSR_ADDR-1:0] ADDR_UNLOCK = 5'h08;
	localparam logic [NB_CSR_ADDR-1:0] ADDR_PERIOD = 5'h0C;
	localparam logic [NB_CSR_ADDR-1:0] ADDR_STATUS = 5'h10;
	localparam logic [NB_CSR_ADDR-1:0] ADDR_RESYNC = 5'h14;

	logic                   wr_fire;
	logic                   rd_fire;
	logic [NB_CSR_DATA-1:0] rd_mux;

	// AW and W taken together, only while no B is pending
	assign o_awready = i_awvalid & i_wvalid & ~o_bvalid;
	assign o_wready  = o_awready;
	assign wr_fire   = o_awready;
	assign o_arready = ~o_rvalid;
	assign rd_fire   = i_arvalid & o_arready;

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_enable     <= 1'b1;
			o_lock_thr   <= NB_VALID_CNT'(4);
			o_unlock_thr <= NB_INVALID_CNT'(4);
			o_am_period  <= NB_AM_PERIOD'(16383);
		end
		else if (wr_fire)
		begin
			case (i_awaddr)	// other addresses dropped
				ADDR_ENABLE: o_enable     <= i_wdata[0];
				ADDR_LOCK:   o_lock_thr   <= i_wdata[NB_VALID_CNT-1:0];
				ADDR_UNLOCK: o_unlock_thr <= i_wdata[NB_INVALID_CNT-1:0];
				ADDR_PERIOD: o_am_period  <= i_wdata[NB_AM_PERIOD-1:0];
				default: ;
			endcase
		end
	end

	always_comb
	begin
		case (i_araddr)
			ADDR_ENABLE: rd_mux = NB_CSR_DATA'(o_enable);
			ADDR_LOCK:   rd_mux = NB_CSR_DATA'(o_lock_thr);
			ADDR_UNLOCK: rd_mux = NB_CSR_DATA'(o_unlock_thr);
			ADDR_PERIOD: rd_mux = NB_CSR_DATA'(o_am_period);
			ADDR_STATUS: rd_mux = {19'd0, i_lane_id, 7'd0, i_am_lock};	// lane id in [12:8]
			ADDR_RESYNC: rd_mux = {16'd0, i_resync_count};
			default:     rd_mux = '0;
		endcase
	end

	// B and R held until the master takes them
	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
		end
		else
		begin
			if (wr_fire)
				o_bvalid <= 1'b1;
			else if (i_bready)
				o_bvalid <= 1'b0;
			if (rd_fire)
				o_rvalid <= 1'b1;
			else if (i_rready)
				o_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge i_clock)
		if (rd_fire)
			o_rdata <= rd_mux;

endmodule

`default_nettype wire

// File: am_lock_top.sv
`timescale 1ns/100ps
`default_nettype none

module am_lock_top
	import am_lock_pkg::*;
#(
	parameter N_ALIGNERS     = 20,
	parameter NB_AM_PERIOD   = 14,
	parameter NB_VALID_CNT   = NB_VALID_CNT_MAX,
	parameter NB_INVALID_CNT = NB_INVALID_CNT_MAX
)
(
	input  wire                    i_clock,
	input  wire                    i_rst_n,
	input  wire                    i_valid,
	input  wire [1:0]              i_sync_header,
	input  wire block66_payload_u  i_payload,
	input  wire                    i_block_lock,
	input  wire [NB_CSR_ADDR-1:0]  i_awaddr,
	input  wire                    i_awvalid,
	output logic                   o_awready,
	input  wire [NB_CSR_DATA-1:0]  i_wdata,
	input  wire                    i_wvalid,
	output logic                   o_wready,
	output logic                   o_bvalid,
	input  wire                    i_bready,
	input  wire [NB_CSR_ADDR-1:0]  i_araddr,
	input  wire                    i_arvalid,
	output logic                   o_arready,
	output logic [NB_CSR_DATA-1:0] o_rdata,
	output logic                   o_rvalid,
	input  wire                    i_rready,
	output logic                   o_am_lock,
	output logic                   o_start_of_lane,
	output logic                   o_resync_by_am_start,
	output logic [4:0]             o_lane_id
);

	logic                      m_valid, m_block_lock, am_valid;	// matcher stage out
	logic [N_ALIGNERS-1:0]     match_vector, match_mask;
	logic                      enable;
	logic [NB_VALID_CNT-1:0]   lock_thr;
	logic [NB_INVALID_CNT-1:0] unlock_thr;
	logic [NB_AM_PERIOD-1:0]   am_period;
	logic [15:0]               resync_count;

	am_matcher #(.N_ALIGNERS(N_ALIGNERS)) u_matcher (
		.i_clock(i_clock), .i_rst_n(i_rst_n), .i_valid(i_valid), .i_block_lock(i_block_lock),
		.i_sync_header(i_sync_header), .i_payload(i_payload), .i_match_mask(match_mask),
		.o_valid(m_valid), .o_block_lock(m_block_lock), .o_match_vector(match_vector),
		.o_am_valid(am_valid));

	am_lock_fsm #(.N_ALIGNERS(N_ALIGNERS), .NB_AM_PERIOD(NB_AM_PERIOD),
		.NB_VALID_CNT(NB_VALID_CNT), .NB_INVALID_CNT(NB_INVALID_CNT)) u_fsm (
		.i_clock(i_clock), .i_rst_n(i_rst_n), .i_enable(enable), .i_valid(m_valid),
		.i_block_lock(m_block_lock), .i_am_valid(am_valid), .i_match_vector(match_vector),
		.i_lock_thr(lock_thr), .i_unlock_thr(unlock_thr), .i_am_period(am_period),
		.o_match_mask(match_mask), .o_am_lock(o_am_lock), .o_start_of_lane(o_start_of_lane),
		.o_resync_by_am_start(o_resync_by_am_start));

	am_lane_status #(.N_ALIGNERS(N_ALIGNERS)) u_status (
		.i_clock(i_clock), .i_rst_n(i_rst_n), .i_am_lock(o_am_lock), .i_match_mask(match_mask),
		.i_resync(o_resync_by_am_start), .o_lane_id(o_lane_id), .o_resync_count(resync_count));

	am_csr_axil #(.NB_AM_PERIOD(NB_AM_PERIOD), .NB_VALID_CNT(NB_VALID_CNT),
		.NB_INVALID_CNT(NB_INVALID_CNT)) u_csr (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
		.i_wdata(i_wdata), .i_wvalid(i_wvalid), .o_wready(o_wready),
		.o_bvalid(o_bvalid), .i_bready(i_bready),
		.i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
		.o_rdata(o_rdata), .o_rvalid(o_rvalid), .i_rready(i_rready),
		.i_am_lock(o_am_lock), .i_lane_id(o_lane_id), .i_resync_count(resync_count),
		.o_enable(enable), .o_lock_thr(lock_thr), .o_unlock_thr(unlock_thr),
		.o_am_period(am_period));

endmodule

`default_nettype wire

// File: am_lock_tb.sv
`timescale 1ns/100ps
`default_nettype none

module am_lock_tb
	import am_lock_pkg::*;
;

	localparam int PERIOD      = 32;	// marker spacing in blocks
	localparam int LOCK_THR    = 3;
	localparam int UNLOCK_THR  = 3;
	localparam int LANE_A      = 7;
	localparam int LANE_B      = 12;
	localparam int LANE_C      = 3;
	localparam int SHIFT       = 5;	// relock offset in blocks
	localparam logic [31:0] SEED = 32'h2723_f34e;

	localparam logic [4:0] ADDR_ENABLE = 5'h00;
	localparam logic [4:0] ADDR_LOCK   = 5'h04;
	localparam logic [4:0] ADDR_UNLOCK = 5'h08;
	localparam logic [4:0] ADDR_PERIOD = 5'h0C;
	localparam logic [4:0] ADDR_STATUS = 5'h10;
	localparam logic [4:0] ADDR_RESYNC = 5'h14;

	// worst case block count of every test with its guard
	localparam int TOTAL_BLOCKS = 3 * (LOCK_THR + 4) * PERIOD + (UNLOCK_THR + 4) * PERIOD
		+ 8 * PERIOD + 16;
	localparam int TIMEOUT_CYCLES = TOTAL_BLOCKS + 2000;

	logic                   i_clock = 1'b0;
	logic                   i_rst_n;
	logic                   i_valid;
	logic [1:0]             i_sync_header;
	block66_payload_u       i_payload;
	logic                   i_block_lock;
	logic [NB_CSR_ADDR-1:0] i_awaddr;
	logic                   i_awvalid;
	logic                   o_awready;
	logic [NB_CSR_DATA-1:0] i_wdata;
	logic                   i_wvalid;
	logic                   o_wready;
	logic                   o_bvalid;
	logic                   i_bready;
	logic [NB_CSR_ADDR-1:0] i_araddr;
	logic                   i_arvalid;
	logic                   o_arready;
	logic [NB_CSR_DATA-1:0] o_rdata;
	logic                   o_rvalid;
	logic                   i_rready;
	logic                   o_am_lock;
	logic                   o_start_of_lane;
	logic                   o_resync_by_am_start;
	logic [4:0]             o_lane_id;

	int  err_count = 0;
	int  check_count = 0;
	int  cycle_count = 0;
	int  blk_idx = 0;	// valid blocks sent so far
	int  am_phase = 16;	// marker slot offset that keeps the first block a data block
	int  markers_to_skip = 0;
	bit  block_lock_level = 1'b1;
	int  sol_pulses = 0;
	int  sol_gap = 0;
	bit  sol_check_en = 1'b0;
	bit  sol_armed = 1'b0;
	int  resync_pulses = 0;
	int  lock_falls = 0;
	bit  lock_q = 1'b0;
	int  seed_init;

	am_lock_top #(
		.N_ALIGNERS(20),
		.NB_AM_PERIOD(14)
	) UUT (
		.i_clock(i_clock), .i_rst_n(i_rst_n), .i_valid(i_valid),
		.i_sync_header(i_sync_header), .i_payload(i_payload), .i_block_lock(i_block_lock),
		.i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
		.i_wdata(i_wdata), .i_wvalid(i_wvalid), .o_wready(o_wready),
		.o_bvalid(o_bvalid), .i_bready(i_bready),
		.i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
		.o_rdata(o_rdata), .o_rvalid(o_rvalid), .i_rready(i_rready),
		.o_am_lock(o_am_lock), .o_start_of_lane(o_start_of_lane),
		.o_resync_by_am_start(o_resync_by_am_start), .o_lane_id(o_lane_id)
	);

	always #4 i_clock = ~i_clock;	// 8 ns period

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			$display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic require(input bit cond, input string what);
		check_count++;
		assert (cond)
		else
		begin
			$display("[ERROR] %0t %s", $time, what);
			err_count++;
		end
	endtask

	function automatic logic [31:0] status_word(input bit lock, input logic [4:0] lane);
		return {19'd0, lane, 7'd0, lock};	// lock in bit 0, lane in [12:8]
	endfunction

	function automatic bit is_marker_slot(input int idx);
		return ((idx - am_phase + 64 * PERIOD) % PERIOD) == 0;
	endfunction

	// samples at negedge where outputs have settled
	always @(negedge i_clock)
	begin
		if (i_rst_n)
		begin
			if (o_resync_by_am_start)
				resync_pulses++;
			if (lock_q && !o_am_lock)
				lock_falls++;
			lock_q = o_am_lock;
			sol_gap++;
			if (o_start_of_lane)
			begin
				sol_pulses++;
				if (sol_check_en && sol_armed)
					compare_value("o_start_of_lane spacing", sol_gap, PERIOD);
				sol_armed = sol_check_en;
				sol_gap = 0;
			end
		end
	end

	always @(posedge i_clock)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("[ERROR] %0t run did not finish within %0d cycles", $time, TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
		@(posedge i_clock);
		i_valid   <= 1'b0;	// no blocks during CSR access
		i_awaddr  <= addr;
		i_awvalid <= 1'b1;
		i_wdata   <= data;
		i_wvalid  <= 1'b1;
		i_bready  <= 1'b1;
		@(negedge i_clock);
		while (!(o_awready && o_wready))
			@(negedge i_clock);
		@(posedge i_clock);
		i_awvalid <= 1'b0;
		i_wvalid  <= 1'b0;
		@(negedge i_clock);
		while (!o_bvalid)
			@(negedge i_clock);
		@(posedge i_clock);
		i_bready <= 1'b0;
		@(negedge i_clock);
	endtask

	task automatic axi_read(input logic [4:0] addr, output logic [31:0] data);
		@(posedge i_clock);
		i_valid   <= 1'b0;
		i_araddr  <= addr;
		i_arvalid <= 1'b1;
		i_rready  <= 1'b1;
		@(negedge i_clock);
		while (!o_arready)
			@(negedge i_clock);
		@(posedge i_clock);
		i_arvalid <= 1'b0;
		@(negedge i_clock);
		while (!o_rvalid)
			@(negedge i_clock);
		data = o_rdata;
		@(posedge i_clock);
		i_rready <= 1'b0;
		@(negedge i_clock);
	endtask

	// one block per call that returns at the following negedge
	task automatic send_block(input bit is_marker, input int lane);
		block66_payload_u       pl;
		logic [NB_AM_CODE-1:0] code;
		logic [7:0]             bip;
		bip = 8'($urandom);
		if (is_marker)
		begin
			code = am_code_table[lane];
			{pl.am.m0, pl.am.m1, pl.am.m2} = code;
			{pl.am.m4, pl.am.m5, pl.am.m6} = ~code;	// complement copy
			pl.am.bip3 = bip;
			pl.am.bip7 = ~bip;
		end
		else
			pl.data = {$urandom, $urandom};
		@(posedge i_clock);
		i_valid       <= 1'b1;
		i_block_lock  <= block_lock_level;
		i_sync_header <= is_marker ? SYNC_CTRL : 2'b01;
		i_payload     <= pl;
		blk_idx++;
		@(negedge i_clock);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge i_clock);
			i_valid <= 1'b0;
			@(negedge i_clock);
		end
	endtask

	// lane < 0 sends data only
	task automatic stream_blocks(input int n, input int lane);
		bit marker;
		repeat (n)
		begin
			marker = (lane >= 0) && is_marker_slot(blk_idx);
			if (marker && markers_to_skip > 0)
			begin
				markers_to_skip--;	// slot filled with data
				marker = 1'b0;
			end
			send_block(marker, lane);
		end
	endtask

	// stream until o_am_lock reaches level within a bound in marker periods
	task automatic await_lock_level(input bit level, input int lane, input int max_periods);
		int ref_idx;
		int guard;
		bit marker;
		ref_idx = (lane < 0) ? blk_idx : -1;	// unlock counts from the start of the data run
		guard = 0;
		while (o_am_lock !== level && guard < (max_periods + 2) * PERIOD)
		begin
			marker = (lane >= 0) && is_marker_slot(blk_idx);
			if (marker && ref_idx < 0)
				ref_idx = blk_idx;
			send_block(marker, lane);
			guard++;
		end
		require(o_am_lock === level && ref_idx >= 0 && (blk_idx - ref_idx) <= max_periods * PERIOD,
			$sformatf("o_am_lock did not reach %0d within %0d marker periods", level, max_periods));
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("%s: %s, %0d errors", name, (err_count == errs_before) ? "ok" : "bad",
			err_count - errs_before);
	endtask

	task automatic register_access();
		logic [4:0]  addrs [4];
		logic [31:0] trial [4];
		logic [31:0] run [4];
		logic [31:0] rd;
		int          errs;
		errs  = err_count;
		addrs = '{ADDR_ENABLE, ADDR_LOCK, ADDR_UNLOCK, ADDR_PERIOD};
		trial = '{32'd0, 32'd17, 32'd5, 32'd1234};
		run   = '{32'd1, LOCK_THR, UNLOCK_THR, PERIOD};	// values kept for later tests
		for (int i = 0; i < 4; i++)
			axi_write(addrs[i], trial[i]);
		for (int i = 0; i < 4; i++)
		begin
			axi_read(addrs[i], rd);
			compare_value($sformatf("rdata reg 0x%0h", addrs[i]), rd, trial[i]);
		end
		for (int i = 0; i < 4; i++)
			axi_write(addrs[i], run[i]);
		axi_write(ADDR_STATUS, 32'hFFFF_FFFF);	// read-only so the write is dropped
		axi_write(5'h18, 32'h0000_0005);	// unmapped
		for (int i = 0; i < 4; i++)
		begin
			axi_read(addrs[i], rd);
			compare_value($sformatf("rdata reg 0x%0h", addrs[i]), rd, run[i]);
		end
		axi_read(ADDR_STATUS, rd);
		compare_value("rdata status", rd, status_word(1'b0, 5'h1F));
		axi_read(ADDR_RESYNC, rd);
		compare_value("rdata resync count", rd, 32'd0);
		report_test("register access", errs);
	endtask

	task automatic lock_acquisition();
		logic [31:0] rd;
		int          errs;
		int          resync_before;
		errs = err_count;
		axi_write(ADDR_PERIOD, PERIOD);
		resync_before = resync_pulses;
		await_lock_level(1'b1, LANE_A, LOCK_THR + 2);
		idle_cycles(2);	// monitor settles before counters are read
		compare_value("o_resync_by_am_start pulses", resync_pulses - resync_before, 1);
		axi_read(ADDR_STATUS, rd);
		compare_value("rdata status", rd, status_word(1'b1, LANE_A));
		axi_read(ADDR_RESYNC, rd);
		compare_value("rdata resync count", rd, 32'd1);
		report_test("lock acquisition", errs);
	endtask

	task automatic start_of_lane_spacing();
		int errs;
		int sol_before;
		int falls_before;
		errs = err_count;
		axi_write(ADDR_PERIOD, PERIOD);
		sol_before   = sol_pulses;
		falls_before = lock_falls;
		sol_check_en = 1'b1;
		stream_blocks(4 * PERIOD, LANE_A);
		markers_to_skip = UNLOCK_THR - 1;	// tolerated run of missing markers
		stream_blocks(4 * PERIOD, LANE_A);
		idle_cycles(2);
		sol_check_en = 1'b0;
		compare_value("o_start_of_lane pulses", sol_pulses - sol_before, 8);
		compare_value("o_am_lock falls", lock_falls - falls_before, 0);
		compare_value("o_am_lock", o_am_lock, 1'b1);
		report_test("start of lane", errs);
	endtask

	task automatic loss_of_lock();
		logic [31:0] rd;
		int          errs;
		int          resync_before;
		errs = err_count;
		axi_write(ADDR_PERIOD, PERIOD);
		resync_before = resync_pulses;
		await_lock_level(1'b0, -1, UNLOCK_THR + 2);
		// same slot grid means relock needs no resync
		await_lock_level(1'b1, LANE_B, LOCK_THR + 2);
		idle_cycles(2);
		compare_value("o_lane_id", o_lane_id, LANE_B);
		compare_value("o_resync_by_am_start pulses", resync_pulses - resync_before, 0);
		axi_read(ADDR_STATUS, rd);
		compare_value("rdata status", rd, status_word(1'b1, LANE_B));
		axi_read(ADDR_RESYNC, rd);
		compare_value("rdata resync count", rd, 32'd1);
		report_test("loss of lock", errs);
	endtask

	task automatic block_lock_drop();
		logic [31:0] rd;
		logic [31:0] count_before;
		int          errs;
		int          resync_before;
		errs = err_count;
		axi_write(ADDR_PERIOD, PERIOD);
		axi_read(ADDR_RESYNC, count_before);
		compare_value("o_am_lock", o_am_lock, 1'b1);
		block_lock_level = 1'b0;
		send_block(1'b0, 0);
		send_block(1'b0, 0);
		send_block(1'b0, 0);	// matcher stage and then the FSM edge
		compare_value("o_am_lock", o_am_lock, 1'b0);
		stream_blocks(4, -1);
		am_phase = (am_phase + SHIFT) % PERIOD;	// markers move by SHIFT blocks
		block_lock_level = 1'b1;
		stream_blocks(2, -1);	// FSM leaves INIT on data
		resync_before = resync_pulses;
		await_lock_level(1'b1, LANE_C, LOCK_THR + 2);
		idle_cycles(2);
		compare_value("o_resync_by_am_start pulses", resync_pulses - resync_before, 1);
		axi_read(ADDR_RESYNC, rd);
		compare_value("rdata resync count", rd, count_before + 1);
		axi_read(ADDR_STATUS, rd);
		compare_value("rdata status", rd, status_word(1'b1, LANE_C));
		report_test("block lock drop", errs);
	endtask

	initial
	begin
		seed_init = $urandom(SEED);	// one seed for the whole run
		i_rst_n       <= 1'b0;
		i_valid       <= 1'b0;
		i_sync_header <= 2'b01;
		i_payload     <= '0;
		i_block_lock  <= 1'b1;
		i_awaddr      <= '0;
		i_awvalid     <= 1'b0;
		i_wdata       <= '0;
		i_wvalid      <= 1'b0;
		i_bready      <= 1'b0;
		i_araddr      <= '0;
		i_arvalid     <= 1'b0;
		i_rready      <= 1'b0;
		repeat (10) @(posedge i_clock);
		i_rst_n <= 1'b1;
		@(negedge i_clock);
		register_access();
		lock_acquisition();
		start_of_lane_spacing();
		loss_of_lock();
		block_lock_drop();
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
am_lock_pkg.sv
am_matcher.sv
am_lock_fsm.sv
am_lane_status.sv
am_csr_axil.sv
am_lock_top.sv
am_lock_tb.sv

// File: Bender.yml
package:
  name: am_lock

sources:
  - am_lock_pkg.sv
  - am_matcher.sv
  - am_lock_fsm.sv
  - am_lane_status.sv
  - am_csr_axil.sv
  - am_lock_top.sv
  - target: simulation
    files:
      - am_lock_tb.sv
